// ==== design/filter_bus_if.sv ====
`default_nettype none
`timescale 1ns/10ps

interface filter_bus_if #(
  parameter int DEPTH = 249
);
  import phase_pkg::*;

  localparam int addr_w = addr_bits(DEPTH);

  logic [addr_w-1:0] addr;
  logic              rd_en;
  offset_t           dout;  // valid the cycle after rd_en, held otherwise

  modport ctrl (
    output addr,
    output rd_en,
    input  dout
  );

  modport mem (
    input  addr,
    input  rd_en,
    output dout
  );

endinterface

`default_nettype wire

// ==== design/offset_ram.sv ====
`default_nettype none
`timescale 1ns/10ps

module offset_ram #(
  parameter int DEPTH = 249
) (
  input  logic                                   CLK,
  input  logic                                   arst_n,
  input  logic                                   wr_en,
  input  logic [phase_pkg::addr_bits(DEPTH)-1:0] wr_addr,
  input  phase_pkg::offset_t                     wr_data,
  filter_bus_if.mem                              ram_bus
);
  import phase_pkg::*;

  offset_t mem [DEPTH];  // one offset per sample position
  offset_t rd_q;

  assign ram_bus.dout = rd_q;

  // host write port
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, holds between reads
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rd_q <= '0;
    end else if (ram_bus.rd_en) begin
      rd_q <= mem[ram_bus.addr];
    end
  end

  // **************************************************
  // checks
  // **************************************************

  // host must stay inside the table
  wr_addr_in_range: assert property (
    @(posedge CLK) disable iff (!arst_n)
      wr_en |-> (wr_addr < DEPTH)
  ) else $error("offset_ram: write address 0x%0h beyond table", wr_addr);

  // filter read sequencing must stop at the last entry
  rd_addr_in_range: assert property (
    @(posedge CLK) disable iff (!arst_n)
      ram_bus.rd_en |-> (ram_bus.addr < DEPTH)
  ) else $error("offset_ram: read address 0x%0h beyond table", ram_bus.addr);

endmodule

`default_nettype wire

// ==== design/phase_filter.sv ====
`default_nettype none
`timescale 1ns/10ps

module phase_filter #(
  parameter int DEPTH = 249
) (
  input  logic               CLK,
  input  logic               arst_n,
  filter_bus_if.ctrl         filter_bus,
  input  logic               din_valid,
  input  phase_pkg::phase_t  phase_in,
  output phase_pkg::phase_t  phase_out,
  output logic               dout_valid
);
  import phase_pkg::*;

  localparam int align_lat = 3;  // matches ram read path
  localparam int add_lat   = 2;
  localparam int fold_lat  = 2;
  localparam int addr_w    = addr_bits(DEPTH);
  localparam int set_w     = $clog2(DEPTH + 1);
  localparam int cnt_w     = $clog2(add_lat + 1);

  filter_state_t state;

  // table read side
  logic [addr_w-1:0] rd_addr;
  logic              rd_en;
  offset_t           offset_val;

  // alignment delay
  phase_t align_q [align_lat];
  phase_t phase_buf;

  // add pipeline
  offset_t a_phase;
  offset_t b_phase;
  offset_t s_phase;

  // fold pipeline
  offset_t a_fold;
  offset_t b_fold;
  logic    add_fold;
  offset_t s_fold;

  // pipeline fill tracking
  logic [cnt_w-1:0] calc_cnt;
  logic [cnt_w-1:0] fold_cnt;
  logic [set_w-1:0] set_cnt;
  logic             out_load;

  assign filter_bus.addr  = rd_addr;
  assign filter_bus.rd_en = rd_en;
  assign offset_val       = filter_bus.dout;

  // **************************************************
  // table read sequencing
  // **************************************************

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rd_en   <= 1'b0;
      rd_addr <= '0;
    end else if (state == idle) begin
      rd_en   <= 1'b0;
      rd_addr <= '0;
    end else if (state == prime_0) begin
      rd_en <= 1'b1;  // first read issued in prime_1
    end else if (rd_en) begin
      if (rd_addr == addr_w'(DEPTH - 1)) begin
        rd_en <= 1'b0;  // last entry issued
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // **************************************************
  // datapath
  // **************************************************

  // sample k leaves the delay with offset k on the bus
  always_ff @(posedge CLK) begin
    align_q[0] <= phase_in;
    for (int i = 1; i < align_lat; i++) begin
      align_q[i] <= align_q[i-1];
    end
  end

  assign phase_buf = align_q[align_lat-1];

  // add, operands then sum
  always_ff @(posedge CLK) begin
    a_phase <= offset_t'({{(offset_w - phase_w){1'b0}}, phase_buf});
    b_phase <= offset_val;
    s_phase <= a_phase + b_phase;
  end

  // fold back into one period, one correction is enough for the offset range
  always_ff @(posedge CLK) begin
    a_fold <= s_phase;
    if (s_phase >= phase_period) begin
      b_fold   <= offset_t'(phase_period);
      add_fold <= 1'b0;
    end else if (s_phase < 0) begin
      b_fold   <= offset_t'(phase_period);
      add_fold <= 1'b1;
    end else begin
      b_fold   <= '0;
      add_fold <= 1'b1;
    end
    s_fold <= add_fold ? (a_fold + b_fold) : (a_fold - b_fold);
  end

  assign out_load = (state == run) && (fold_cnt == cnt_w'(fold_lat)) &&
                    (set_cnt != set_w'(DEPTH));

  always_ff @(posedge CLK) begin
    if (out_load) begin
      phase_out <= s_fold[phase_w-1:0];
    end
  end

  // **************************************************
  // frame FSM
  // **************************************************

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state      <= idle;
      calc_cnt   <= '0;
      fold_cnt   <= '0;
      set_cnt    <= '0;
      dout_valid <= 1'b0;
    end else begin
      case (state)
        idle: begin
          dout_valid <= 1'b0;
          if (din_valid) begin  // sample 0 arrives with the pulse
            calc_cnt <= '0;
            fold_cnt <= '0;
            set_cnt  <= '0;
            state    <= prime_0;
          end
        end
        prime_0: begin
          state <= prime_1;
        end
        prime_1: begin
          state <= run;
        end
        run: begin
          // sum pipeline full first, then fold pipeline
          if (calc_cnt != cnt_w'(add_lat)) begin
            calc_cnt <= calc_cnt + 1'b1;
          end else if (fold_cnt != cnt_w'(fold_lat)) begin
            fold_cnt <= fold_cnt + 1'b1;
          end

          if (out_load) begin
            dout_valid <= 1'b1;
            set_cnt    <= set_cnt + 1'b1;
          end else if (set_cnt == set_w'(DEPTH)) begin
            dout_valid <= 1'b0;  // frame done
            state      <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // **************************************************
  // checks
  // **************************************************

  no_valid_in_idle: assert property (
    @(posedge CLK) disable iff (!arst_n)
      (state == idle) |-> !dout_valid
  ) else $error("phase_filter: dout_valid high in idle");

  // the offset range guarantees one fold suffices
  fold_in_period: assert property (
    @(posedge CLK) disable iff (!arst_n)
      out_load |-> ((s_fold >= 0) && (s_fold < phase_period))
  ) else $error("phase_filter: folded value 0x%0h outside one period", s_fold);

endmodule

`default_nettype wire

// ==== design/phase_pkg.sv ====
`default_nettype none

package phase_pkg;

  // sample and sum widths
  localparam int phase_w  = 8;
  localparam int offset_w = 10;  // holds [-256, 510] without overflow

  // one phase period, results wrap into [0, phase_period-1]
  localparam int phase_period = 256;

  typedef logic [phase_w-1:0] phase_t;
  typedef logic signed [offset_w-1:0] offset_t;

  // filter frame FSM
  typedef enum logic [1:0] {
    idle,
    prime_0,  // read pipeline fill
    prime_1,
    run
  } filter_state_t;

  // table address width for a given frame length
  function automatic int addr_bits(input int depth);
    int bits;
    bits = (depth > 1) ? $clog2(depth) : 1;
    return bits;
  endfunction

endpackage

`default_nettype wire

// ==== design/phase_shift_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module phase_shift_top #(
  parameter int DEPTH = 249
) (
  input  logic                                   CLK,
  input  logic                                   arst_n,

  // offset table load
  input  logic                                   wr_en,
  input  logic [phase_pkg::addr_bits(DEPTH)-1:0] wr_addr,
  input  phase_pkg::offset_t                     wr_data,

  // phase stream in
  input  logic                                   din_valid,
  input  phase_pkg::phase_t                      phase_in,

  // phase stream out
  output phase_pkg::phase_t                      phase_out,
  output logic                                   dout_valid
);

  filter_bus_if #(
    .DEPTH(DEPTH)
  ) filter_bus ();

  offset_ram #(
    .DEPTH(DEPTH)
  ) offset_ram_inst (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .ram_bus (filter_bus.mem)
  );

  phase_filter #(
    .DEPTH(DEPTH)
  ) phase_filter_inst (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .filter_bus (filter_bus.ctrl),
    .din_valid  (din_valid),
    .phase_in   (phase_in),
    .phase_out  (phase_out),
    .dout_valid (dout_valid)
  );

endmodule

`default_nettype wire

// ==== flist.f ====
design/phase_pkg.sv
design/filter_bus_if.sv
design/offset_ram.sv
design/phase_filter.sv
design/phase_shift_top.sv
tb/phase_shift_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the phase shift testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module phase_shift_tb -o phase_shift_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/phase_shift_sim > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// ==== tb/phase_shift_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module phase_shift_tb;
  import phase_pkg::*;

  localparam int DEPTH        = 16;
  localparam int addr_w       = $clog2(DEPTH);
  localparam int lat          = 8;  // input sample to output register
  localparam int n_frames     = 8;
  localparam int reset_cycles = 4;
  localparam int cycle_limit  = reset_cycles + 1 + n_frames * (DEPTH + lat + DEPTH + 10);

  logic              CLK = 1'b0;
  logic              arst_n;
  logic              wr_en;
  logic [addr_w-1:0] wr_addr;
  offset_t           wr_data;
  logic              din_valid;
  phase_t            phase_in;
  phase_t            phase_out;
  logic              dout_valid;

  // stimulus table, one row per frame
  offset_t tbl_off [n_frames][DEPTH];
  phase_t  tbl_ph [n_frames][DEPTH];
  int      tbl_restart [n_frames];  // sample index of an extra pulse, 0 for none

  phase_t        exp_q [$];
  int            seed = 3070;
  int            cycle_cnt = 0;
  int            valid_run = 0;
  int            frames_done = 0;
  filter_state_t stuck_state;

  phase_shift_top #(
    .DEPTH(DEPTH)
  ) phase_shift_top_inst (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .din_valid  (din_valid),
    .phase_in   (phase_in),
    .phase_out  (phase_out),
    .dout_valid (dout_valid)
  );

  always #50 CLK = ~CLK;

  // **************************************************
  // reference model and compare tasks
  // **************************************************

  function automatic phase_t expected_phase(input phase_t p, input offset_t o);
    int s;
    s = int'(p) + int'(o);
    if (s >= phase_period) begin
      s = s - phase_period;
    end else if (s < 0) begin
      s = s + phase_period;
    end
    return phase_t'(s);
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_phase(input phase_t got, input phase_t exp);
    if (got !== exp) begin
      fail_now($sformatf("FAIL phase_out got 0x%02h expected 0x%02h", got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      fail_now($sformatf("FAIL dout_valid run length got 0x%0h expected 0x%0h", got, exp));
    end
  endtask

  task automatic check_idle(input logic got);
    if (got !== 1'b0) begin
      fail_now($sformatf("FAIL dout_valid got 0x%0h expected 0x0", got));
    end
  endtask

  // **************************************************
  // stimulus
  // **************************************************

  task automatic build_table();
    int r;
    for (int k = 0; k < DEPTH; k++) begin
      tbl_off[0][k] = '0;  // pass-through
      tbl_ph[0][k]  = phase_t'(k * 17 + 3);
      tbl_off[1][k] = offset_t'(16 + k * 15);  // wraps past 255
      tbl_ph[1][k]  = phase_t'(240 + k);
      tbl_off[2][k] = offset_t'(-(1 + k * 17));  // wraps below 0
      tbl_ph[2][k]  = phase_t'(k * 3);
      tbl_off[3][k] = (k % 2 == 1) ? offset_t'(100) : offset_t'(-100);
      tbl_ph[3][k]  = phase_t'(k * 16);
    end
    tbl_off[1][DEPTH-1] = offset_t'(255);  // largest sum
    tbl_off[2][DEPTH-1] = offset_t'(-256);
    tbl_restart[0] = 0;
    tbl_restart[1] = 0;
    tbl_restart[2] = 0;
    tbl_restart[3] = 6;
    for (int f = 4; f < n_frames; f++) begin
      for (int k = 0; k < DEPTH; k++) begin
        r = $random(seed);
        tbl_off[f][k] = offset_t'((r & 511) - 256);
        r = $random(seed);
        tbl_ph[f][k] = phase_t'(r & 255);
      end
      tbl_restart[f] = (f == 6) ? 11 : 0;
    end
  endtask

  task automatic run_frame(input int f);
    // table load, filter must stay quiet
    for (int i = 0; i < DEPTH; i++) begin
      @(posedge CLK);
      #1;
      wr_en   = 1'b1;
      wr_addr = addr_w'(i);
      wr_data = tbl_off[f][i];
      @(negedge CLK);
      check_idle(dout_valid);
    end
    for (int k = 0; k < DEPTH; k++) begin
      exp_q.push_back(expected_phase(tbl_ph[f][k], tbl_off[f][k]));
    end
    // sample 0 goes with the pulse
    for (int k = 0; k < DEPTH; k++) begin
      @(posedge CLK);
      #1;
      wr_en     = 1'b0;
      din_valid = (k == 0) || (k == tbl_restart[f]);
      phase_in  = tbl_ph[f][k];
    end
    @(posedge CLK);
    #1;
    din_valid = 1'b0;
    phase_in  = '0;
    while (frames_done <= f) begin
      @(posedge CLK);
    end
    repeat (2) begin
      @(negedge CLK);
      check_idle(dout_valid);
    end
  endtask

  // **************************************************
  // monitor and timeout
  // **************************************************

  always @(negedge CLK) begin
    if (arst_n) begin
      if (dout_valid) begin
        if (exp_q.size() == 0) begin
          fail_now("dout_valid high while no result was expected");
        end else begin
          check_phase(phase_out, exp_q.pop_front());
          valid_run++;
        end
      end else if (valid_run != 0) begin
        check_count(valid_run, DEPTH);  // run just ended
        valid_run = 0;
        frames_done++;
      end
    end
  end

  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      stuck_state = phase_shift_top_inst.phase_filter_inst.state;
      $display("timeout after %0d cycles with %0d frames done, filter state %s",
               cycle_cnt, frames_done, stuck_state.name());
      $display("TEST FAILED");
      $fatal(1, "simulation did not finish in time");
    end
  end

  initial begin
    arst_n    = 1'b0;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    din_valid = 1'b0;
    phase_in  = '0;
    build_table();
    repeat (reset_cycles) begin
      @(negedge CLK);
      check_idle(dout_valid);
    end
    @(posedge CLK);
    #1;
    arst_n = 1'b1;
    for (int f = 0; f < n_frames; f++) begin
      run_frame(f);
    end
    if ((exp_q.size() == 0) && (frames_done == n_frames)) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("%0d expected results never appeared", exp_q.size());
      $display("TEST FAILED");
      $fatal(1, "results missing at end of run");
    end
  end

endmodule

`default_nettype wire
